/* Makefile */
# Verilator build for the memory hierarchy testbench

VERILATOR ?= verilator
TOP       ?= tbMemHierarchy
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	-./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* apbFrontend.sv */
module apbFrontend (
    input  logic             clk,
    input  logic             rstn,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [3:0]       paddr,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    output memPkg::memReq_t  req,
    input  memPkg::memResp_t resp
);

    typedef enum logic [1:0] {
        idle,
        waitResp,
        done
    } feState_t;

    feState_t state;
    feState_t nextState;

    memPkg::memOp_t                 cmdOp;
    memPkg::memOp_t                 pendOp;     // Op of the command in flight
    logic [memPkg::addrWidth-1:0]   cmdAddr;
    logic [memPkg::dataWidth-1:0]   cmdData;

    logic access;
    logic cmdWrite;
    logic resRead;
    logic badAccess;
    logic misaligned;
    logic issue;
    logic reject;

    // Result register
    logic                         resErr;
    logic                         resHit;
    logic [memPkg::dataWidth-1:0] resData;

    assign access    = psel && penable;
    assign cmdWrite  = access && pwrite && (paddr == memPkg::regCmd);
    assign resRead   = access && !pwrite && (paddr == memPkg::regResult);
    assign badAccess = access && !cmdWrite && !resRead;

    // Command word decode
    assign cmdOp   = memPkg::memOp_t'(pwdata[memPkg::cmdOpLsb +: 2]);
    assign cmdData = pwdata[memPkg::cmdDataLsb +: memPkg::dataWidth];
    assign cmdAddr = pwdata[memPkg::cmdAddrLsb +: memPkg::addrWidth];

    assign misaligned = cmdAddr[0] &&
                        ((cmdOp == memPkg::opLoad) || (cmdOp == memPkg::opStoreHalf));
    assign issue  = (state == idle) && cmdWrite && (cmdOp != memPkg::opNone) && !misaligned;
    assign reject = (state == idle) && cmdWrite && misaligned;

    always_comb begin
        req.valid = issue;      // One cycle, first access cycle only
        req.op    = cmdOp;
        req.addr  = cmdAddr;
        req.data  = cmdData;
    end

    // Everything except an issued command finishes in its first access cycle
    assign pready  = access && ((state == done) || ((state == idle) && !issue));
    assign pslverr = pready && (state == idle) && (badAccess || reject);

    always_comb begin
        prdata = '0;
        if (resRead) begin
            prdata[memPkg::resErrBit]           = resErr;
            prdata[memPkg::resHitBit]           = resHit;
            prdata[memPkg::dataWidth-1:0]       = resData;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idle:     if (issue) nextState = waitResp;
            waitResp: if (resp.valid) nextState = done;
            done:     nextState = idle;  // pready is high here
            default:  nextState = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) pendOp <= cmdOp;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            resErr  <= 1'b0;
            resHit  <= 1'b0;
            resData <= '0;
        end else if (reject) begin
            resErr <= 1'b1;
        end else if ((state == idle) && cmdWrite && (cmdOp == memPkg::opNone)) begin
            resErr <= 1'b0;
        end else if ((state == waitResp) && resp.valid) begin
            resErr <= 1'b0;
            if (pendOp == memPkg::opLoad) begin   // Stores leave load data alone
                resHit  <= resp.hit;
                resData <= resp.data;
            end
        end
    end

endmodule

/* cacheStage.sv */
module cacheStage (
    input  logic             clk,
    input  logic             rstn,
    input  memPkg::memReq_t  req,
    output memPkg::memResp_t resp,
    output memPkg::memReq_t  memReq,
    input  memPkg::memResp_t memResp
);

    localparam int idxW = memPkg::idxWidth;
    localparam int tagW = memPkg::tagWidth;

    // Line storage
    logic [memPkg::cacheLines-1:0] lineValid;
    logic [tagW-1:0]               lineTag  [memPkg::cacheLines];
    logic [memPkg::dataWidth-1:0]  lineData [memPkg::cacheLines];

    logic [idxW-1:0] reqIdx;
    logic [tagW-1:0] reqTag;
    logic            reqHit;
    logic            isLoad;
    logic            isStore;
    logic            loadMiss;

    // Outstanding refill
    logic            pendLoad;
    logic [idxW-1:0] pendIdx;
    logic [tagW-1:0] pendTag;

    // Registered hit answer
    logic                         hitValid;
    logic [memPkg::dataWidth-1:0] hitData;

    assign reqIdx = req.addr[idxW:1];
    assign reqTag = req.addr[memPkg::addrWidth-1:idxW+1];
    assign reqHit = lineValid[reqIdx] && (lineTag[reqIdx] == reqTag);

    assign isLoad   = req.valid && (req.op == memPkg::opLoad);
    assign isStore  = req.valid &&
                      ((req.op == memPkg::opStoreHalf) || (req.op == memPkg::opStoreByte));
    assign loadMiss = isLoad && !reqHit;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lineValid <= '0;
            pendLoad  <= 1'b0;
            hitValid  <= 1'b0;
            memReq    <= '0;
        end else begin
            hitValid     <= isLoad && reqHit;
            memReq       <= req;
            memReq.valid <= loadMiss || isStore;   // Write-through, misses go down
            if (loadMiss) begin
                pendLoad <= 1'b1;
            end else if (memResp.valid) begin
                pendLoad <= 1'b0;
            end
            if (memResp.valid && pendLoad) lineValid[pendIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (loadMiss) begin
            pendIdx <= reqIdx;
            pendTag <= reqTag;
        end
        if (isLoad && reqHit) hitData <= lineData[reqIdx];

        // Refill replaces whatever sat in the line
        if (memResp.valid && pendLoad) begin
            lineTag[pendIdx]  <= pendTag;
            lineData[pendIdx] <= memResp.data;
        end

        // Store hit patches the cached copy, misses do not allocate
        if (isStore && reqHit) begin
            if (req.op == memPkg::opStoreHalf) begin
                lineData[reqIdx] <= req.data;
            end else if (req.addr[0]) begin
                lineData[reqIdx][15:8] <= req.data[7:0];
            end else begin
                lineData[reqIdx][7:0] <= req.data[7:0];
            end
        end
    end

    // Memory completion passes straight through, hits come from the register
    always_comb begin
        resp = '0;
        if (memResp.valid) begin
            resp.valid = 1'b1;
            resp.hit   = 1'b0;
            resp.data  = memResp.data;
        end else if (hitValid) begin
            resp.valid = 1'b1;
            resp.hit   = 1'b1;
            resp.data  = hitData;
        end
    end

endmodule

/* dataMemory.sv */
module dataMemory (
    input  logic             clk,
    input  logic             rstn,
    input  memPkg::memReq_t  memReq,
    output memPkg::memResp_t memResp
);

    localparam int depth = memPkg::memLatency;

    memPkg::memReq_t stage [depth];     // Delay line, one request per slot
    memPkg::memReq_t tail;

    logic [7:0]                   mem [memPkg::memBytes];
    logic [memPkg::addrWidth-1:0] upAddr;   // Address of the high byte

    assign tail   = stage[depth-1];
    assign upAddr = tail.addr + memPkg::addrWidth'(1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < depth; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= memReq;
            for (int i = 1; i < depth; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    // The access itself happens when a request leaves the last slot
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < memPkg::memBytes; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (tail.valid) begin
            case (tail.op)
                memPkg::opStoreHalf: begin
                    mem[tail.addr] <= tail.data[7:0];   // Little endian
                    mem[upAddr]    <= tail.data[15:8];
                end
                memPkg::opStoreByte: begin
                    mem[tail.addr] <= tail.data[7:0];
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        memResp.valid = tail.valid;
        memResp.hit   = 1'b0;
        if (tail.op == memPkg::opLoad) begin
            memResp.data = {mem[upAddr], mem[tail.addr]};
        end else begin
            memResp.data = '0;   // Stores only acknowledge
        end
    end

endmodule

/* memHierarchy.sv */
module memHierarchy (
    input  logic        clk,
    input  logic        rstn,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    memPkg::memReq_t  req;      // Front end to cache
    memPkg::memResp_t resp;
    memPkg::memReq_t  memReq;   // Cache to backing memory
    memPkg::memResp_t memResp;

    apbFrontend uFrontend (
        .clk     (clk),
        .rstn    (rstn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .req     (req),
        .resp    (resp)
    );

    cacheStage uCache (
        .clk     (clk),
        .rstn    (rstn),
        .req     (req),
        .resp    (resp),
        .memReq  (memReq),
        .memResp (memResp)
    );

    dataMemory uMemory (
        .clk     (clk),
        .rstn    (rstn),
        .memReq  (memReq),
        .memResp (memResp)
    );

endmodule

/* memPkg.sv */
package memPkg;

    // Backing memory geometry
    localparam int memBytes   = 1024;
    localparam int addrWidth  = $clog2(memBytes);   // Byte address, 10 bits
    localparam int dataWidth  = 16;                 // One halfword
    localparam int memLatency = 10;                 // Delay stages in front of the array

    // Direct-mapped cache with one aligned halfword per line
    localparam int cacheLines = 16;
    localparam int idxWidth   = $clog2(cacheLines); // Index is addr[4:1]
    localparam int tagWidth   = addrWidth - idxWidth - 1; // Tag is addr[9:5]

    typedef enum logic [1:0] {
        opNone      = 2'd0,
        opLoad      = 2'd1,
        opStoreHalf = 2'd2,
        opStoreByte = 2'd3
    } memOp_t;

    // Request passed from stage to stage
    typedef struct packed {
        logic                 valid;
        memOp_t               op;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] data;
    } memReq_t;

    // Completion travelling back toward the APB side
    typedef struct packed {
        logic                 valid;
        logic                 hit;
        logic [dataWidth-1:0] data;
    } memResp_t;

    // APB register map
    localparam logic [3:0] regCmd    = 4'h0;
    localparam logic [3:0] regResult = 4'h4;

    // Command word fields
    localparam int cmdOpLsb   = 30;   // op in 31:30
    localparam int cmdDataLsb = 10;   // data in 25:10
    localparam int cmdAddrLsb = 0;    // addr in 9:0

    // Result word fields
    localparam int resHitBit  = 16;
    localparam int resErrBit  = 17;

endpackage

/* project.f */
memPkg.sv
apbFrontend.sv
cacheStage.sv
dataMemory.sv
memHierarchy.sv
tbMemHierarchy.sv

/* tbMemHierarchy.sv */
module tbMemHierarchy;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int randCount = 200;

    typedef struct packed {
        memPkg::memOp_t op;
        logic [9:0]     addr;
        logic [15:0]    data;
        logic [15:0]    expData;
        logic           expHit;
        logic           expErr;
    } tableRow_t;

    logic        clk;
    logic        rstn;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    tableRow_t rowQ[$];
    string     nameQ[$];

    // Reference models of the memory bytes and the cached tags
    logic [7:0] memModel [memPkg::memBytes];
    logic       tagValid [memPkg::cacheLines];
    logic [4:0] tagStore [memPkg::cacheLines];
    logic       lastHit;
    logic [15:0] lastData;

    int cycles;
    int cycleLimit;

    memHierarchy dut (
        .clk     (clk),
        .rstn    (rstn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic reportMismatch(input string name, input string what,
                                  input logic [31:0] expected, input logic [31:0] actual);
        $display("error: %s %s expected 0x%0h actual 0x%0h", name, what, expected, actual);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycleLimit > 0 && cycles > cycleLimit) begin
            abortRun($sformatf("timeout: run did not finish within %0d cycles", cycleLimit));
        end
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Setup cycle, then access cycles until pready; waits counts cycles after the first
    task automatic apbWrite(input logic [3:0] a, input logic [31:0] d,
                            output int waits, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        pwrite  <= 1'b1;
        paddr   <= a;
        pwdata  <= d;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        waits = 0;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
            waits++;
        end
        err = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apbRead(input logic [3:0] a, output logic [31:0] d, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        pwrite  <= 1'b0;
        paddr   <= a;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) @(negedge clk);
        d   = prdata;
        err = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    function automatic logic predictHit(input logic [9:0] addr);
        return tagValid[addr[4:1]] && (tagStore[addr[4:1]] == addr[9:5]);
    endfunction

    task automatic applyModel(input memPkg::memOp_t op, input logic [9:0] addr,
                              input logic [15:0] data, input logic err);
        if (!err) begin
            case (op)
                memPkg::opLoad: begin    // Any load leaves its line cached
                    tagValid[addr[4:1]] = 1'b1;
                    tagStore[addr[4:1]] = addr[9:5];
                end
                memPkg::opStoreHalf: begin
                    memModel[addr]         = data[7:0];
                    memModel[addr + 10'd1] = data[15:8];
                end
                memPkg::opStoreByte: memModel[addr] = data[7:0];
                default: ;
            endcase
        end
    endtask

    task automatic runCommand(input string name, input memPkg::memOp_t op,
                              input logic [9:0] addr, input logic [15:0] data,
                              input logic [15:0] expData, input logic expHit,
                              input logic expErr);
        logic [31:0] word;
        logic [31:0] rd;
        logic [31:0] expWord;
        logic        err;
        int          waits;
        int          expWaits;
        word = '0;
        word[memPkg::cmdOpLsb +: 2]    = op;
        word[memPkg::cmdDataLsb +: 16] = data;
        word[memPkg::cmdAddrLsb +: 10] = addr;
        if (expErr || op == memPkg::opNone) expWaits = 0;
        else if (op == memPkg::opLoad && expHit) expWaits = 2;
        else expWaits = 12;    // Round trip through the backing memory
        apbWrite(memPkg::regCmd, word, waits, err);
        assert (err === expErr) else reportMismatch(name, "pslverr", 32'(expErr), 32'(err));
        assert (waits == expWaits) else reportMismatch(name, "wait cycles", expWaits, waits);
        if (op == memPkg::opLoad && !expErr) begin
            lastHit  = expHit;
            lastData = expData;
        end
        apbRead(memPkg::regResult, rd, err);
        assert (err === 1'b0) else reportMismatch(name, "result pslverr", 32'd0, 32'(err));
        expWord = {14'd0, expErr, lastHit, lastData};
        assert (rd === expWord) else reportMismatch(name, "result", expWord, rd);
    endtask

    task automatic expectSlvErr(input string name, input logic isWrite, input logic [3:0] a);
        logic [31:0] rd;
        logic        err;
        int          waits;
        if (isWrite) begin
            apbWrite(a, 32'hffff_ffff, waits, err);
            assert (waits == 0) else reportMismatch(name, "wait cycles", 32'd0, waits);
        end else begin
            apbRead(a, rd, err);
        end
        assert (err === 1'b1) else reportMismatch(name, "pslverr", 32'd1, 32'(err));
    endtask

    task automatic addRow(input string name, input memPkg::memOp_t op, input logic [9:0] addr,
                          input logic [15:0] data, input logic [15:0] expData,
                          input logic expHit, input logic expErr);
        tableRow_t row;
        row.op      = op;
        row.addr    = addr;
        row.data    = data;
        row.expData = expData;
        row.expHit  = expHit;
        row.expErr  = expErr;
        rowQ.push_back(row);
        nameQ.push_back(name);
    endtask

    // 0x010 and 0x030 share index 8, 0x100 sits at index 0 with tag 8
    task automatic buildTable();
        addRow("ldColdA",      memPkg::opLoad,      10'h010, 16'h0000, 16'h0000, 1'b0, 1'b0);
        addRow("ldWarmA",      memPkg::opLoad,      10'h010, 16'h0000, 16'h0000, 1'b1, 1'b0);
        addRow("stHalfA",      memPkg::opStoreHalf, 10'h010, 16'hbeef, 16'h0000, 1'b0, 1'b0);
        addRow("ldAfterSt",    memPkg::opLoad,      10'h010, 16'h0000, 16'hbeef, 1'b1, 1'b0);
        addRow("stHalfB",      memPkg::opStoreHalf, 10'h030, 16'h1234, 16'h0000, 1'b0, 1'b0);
        addRow("ldAlias",      memPkg::opLoad,      10'h030, 16'h0000, 16'h1234, 1'b0, 1'b0);
        addRow("ldEvicted",    memPkg::opLoad,      10'h010, 16'h0000, 16'hbeef, 1'b0, 1'b0);
        addRow("stByteHit",    memPkg::opStoreByte, 10'h011, 16'h77a5, 16'h0000, 1'b0, 1'b0);
        addRow("ldMergedHit",  memPkg::opLoad,      10'h010, 16'h0000, 16'ha5ef, 1'b1, 1'b0);
        addRow("stHalfC",      memPkg::opStoreHalf, 10'h100, 16'hcafe, 16'h0000, 1'b0, 1'b0);
        addRow("stByteMiss",   memPkg::opStoreByte, 10'h101, 16'h0042, 16'h0000, 1'b0, 1'b0);
        addRow("ldMergedMiss", memPkg::opLoad,      10'h100, 16'h0000, 16'h42fe, 1'b0, 1'b0);
        addRow("stByteLow",    memPkg::opStoreByte, 10'h100, 16'h0011, 16'h0000, 1'b0, 1'b0);
        addRow("ldByteLow",    memPkg::opLoad,      10'h100, 16'h0000, 16'h4211, 1'b1, 1'b0);
        addRow("ldOdd",        memPkg::opLoad,      10'h021, 16'h0000, 16'h0000, 1'b0, 1'b1);
        addRow("stHalfOdd",    memPkg::opStoreHalf, 10'h011, 16'hffff, 16'h0000, 1'b0, 1'b1);
        addRow("ldAliasAgain", memPkg::opLoad,      10'h030, 16'h0000, 16'h1234, 1'b0, 1'b0);
        addRow("ldMemOdd",     memPkg::opLoad,      10'h010, 16'h0000, 16'ha5ef, 1'b0, 1'b0);
        addRow("nop",          memPkg::opNone,      10'h000, 16'h0000, 16'h0000, 1'b0, 1'b0);
    endtask

    initial begin
        logic [31:0]    r;
        logic [31:0]    seed;
        logic [31:0]    rd;
        logic           err;
        memPkg::memOp_t op;
        logic [9:0]     addr;
        logic [15:0]    data;
        rstn     = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        cycles   = 0;
        lastHit  = 1'b0;
        lastData = '0;
        for (int i = 0; i < memPkg::memBytes; i++) memModel[i] = 8'h00;
        for (int i = 0; i < memPkg::cacheLines; i++) begin
            tagValid[i] = 1'b0;
            tagStore[i] = '0;
        end
        buildTable();
        cycleLimit = (rowQ.size() + randCount) * 30;

        repeat (4) @(posedge clk);
        rstn <= 1'b1;

        foreach (rowQ[i]) begin
            runCommand(nameQ[i], rowQ[i].op, rowQ[i].addr, rowQ[i].data,
                       rowQ[i].expData, rowQ[i].expHit, rowQ[i].expErr);
            applyModel(rowQ[i].op, rowQ[i].addr, rowQ[i].data, rowQ[i].expErr);
        end

        expectSlvErr("badWrite8", 1'b1, 4'h8);
        expectSlvErr("badReadC", 1'b0, 4'hc);
        expectSlvErr("writeResult", 1'b1, memPkg::regResult);
        expectSlvErr("readCmd", 1'b0, memPkg::regCmd);
        apbRead(memPkg::regResult, rd, err);
        assert (rd === {14'd0, 1'b0, lastHit, lastData})
            else reportMismatch("resultKept", "result", {14'd0, 1'b0, lastHit, lastData}, rd);

        // Random mix over the low 256 bytes so lines alias often
        seed = 32'hd0c9;
        for (int i = 0; i < randCount; i++) begin
            seed = lcgNext(seed);
            r    = seed;
            case (r[31:30])
                2'd0, 2'd1: op = memPkg::opLoad;
                2'd2:       op = memPkg::opStoreHalf;
                default:    op = memPkg::opStoreByte;
            endcase
            addr = {2'b00, r[23:16]};
            if (op != memPkg::opStoreByte && r[28:26] != 3'd0) addr[0] = 1'b0;
            seed = lcgNext(seed);
            data = seed[31:16];
            err  = (op != memPkg::opStoreByte) && addr[0];
            runCommand($sformatf("rand%0d", i), op, addr, data,
                       {memModel[addr + 10'd1], memModel[addr]}, predictHit(addr), err);
            applyModel(op, addr, data, err);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule
